//--- hw/i2cPkg.sv
/* Shared widths, register offsets and sequencer states of the I2C keypad block.
   Offsets are byte addresses within the block; only the low 4 address bits decode. */
`default_nettype none

package i2cPkg;

	//------------------------------------------------------------------
	// Widths
	//------------------------------------------------------------------
	localparam int I2C_DIV_BITS  = 16;	// SCL divider register
	localparam int KEYPAD_BITS   = 16;	// Two bytes from the port expander
	localparam int BUS_DATA_BITS = 32;	// Bus data word

	//------------------------------------------------------------------
	// Register offsets
	//------------------------------------------------------------------
	localparam logic [3:0] REG_CTRL   = 4'h0;	// Bit 0 enable
	localparam logic [3:0] REG_DIV    = 4'h4;	// Quarter-bit divider
	localparam logic [3:0] REG_KEYPAD = 4'h8;	// Read only
	localparam logic [3:0] REG_STATUS = 4'hC;	// Sticky, write 1 to clear

	// Sequencer states, one SCL period per bit
	typedef enum logic [3:0] {
		IDLE,		// SCL parked high, waiting for enable
		START,		// SDA falls while SCL high
		ADDR,		// 7-bit address plus read bit
		ADDR_ACK,	// Slave acknowledge
		RDHI,		// First data byte, upper half
		ACKHI,		// Master ACK
		RDLO,		// Second data byte
		NACKLO,		// Master NACK ends the read
		STOP,		// SDA rises while SCL high
		GAP			// Bus free time before the next START
	} i2cSeqState;

endpackage

`default_nettype wire

//--- hw/i2cCtrlIf.sv
/* Control and status between register space and I2C unit.
   seqComp and addrNack are single-cycle strobes; keyPad is valid with seqComp. */
`timescale 1ns/1ps
`default_nettype none

interface i2cCtrlIf;

	logic								en;			// Run repeated reads
	logic	[i2cPkg::I2C_DIV_BITS-1:0]	div;		// Cycles per quarter bit, minus one
	logic	[i2cPkg::KEYPAD_BITS-1:0]	keyPad;		// Last word read
	logic								seqComp;	// Read done strobe
	logic								addrNack;	// Address not acknowledged

	// Register side
	modport csr (
		output	en,
		output	div,
		input	keyPad,
		input	seqComp,
		input	addrNack
	);

	// Engine side
	modport unit (
		input	en,
		input	div,
		output	keyPad,
		output	seqComp,
		output	addrNack
	);

endinterface

`default_nettype wire

//--- hw/I2CSclGen.sv
/* Quarter-bit tick every div+1 cycles; SCL period is 4*(div+1) cycles.
   A new divider takes effect at the next reload. */
`timescale 1ns/1ps
`default_nettype none

module I2CSclGen (
	input	wire								sysClk,
	input	wire								rstN,
	input	wire	[i2cPkg::I2C_DIV_BITS-1:0]	div,
	input	wire								run,
	output	logic								tick,	// First cycle of a new phase
	output	logic	[1:0]						phase,
	output	logic								scl
);

	logic	[i2cPkg::I2C_DIV_BITS-1:0]	cnt;
	logic								wrap;

	assign wrap = (cnt == '0);

	//------------------------------------------------------------------
	// Divider and phase counter
	//------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt		<= '0;
			tick	<= 1'b0;
			phase	<= 2'd2;	// Parked, SCL high
		end
		else
		begin
			tick <= wrap;
			if (wrap)
			begin
				cnt <= div;		// Reload
				if (run)
					phase <= phase + 2'd1;
				else
					phase <= 2'd2;	// Park while idle
			end
			else
				cnt <= cnt - 1'b1;
		end
	end

	// Low in phases 0,1 and high in 2,3
	assign scl = phase[1];

endmodule

`default_nettype wire

//--- hw/I2CKeyPadSeq.sv
/* Repeats START, address+R, two data bytes (ACK then NACK), STOP while en is set.
   Data bits change on phase-0 ticks, sampling on phase-2; START/STOP edges on phase 3. */
`timescale 1ns/1ps
`default_nettype none

module I2CKeyPadSeq #(
	parameter	logic	[6:0]	pDevAdrs = 7'h20
)(
	input	wire								sysClk,
	input	wire								rstN,
	input	wire								en,
	input	wire								tick,
	input	wire	[1:0]						phase,
	input	wire								sdaIn,		// Synchronized
	output	logic								sdaLow,
	output	logic								run,
	output	logic	[i2cPkg::KEYPAD_BITS-1:0]	keyPad,
	output	logic								seqComp,	// Strobe, keyPad valid
	output	logic								addrNack	// Strobe
);

	localparam logic [7:0] lpAddrByte = {pDevAdrs, 1'b1};	// Read bit set

	i2cPkg::i2cSeqState					state;
	logic	[2:0]						bitCnt;		// Bits left in the byte
	logic	[i2cPkg::KEYPAD_BITS-1:0]	dataSh;		// MSB first
	logic								nackSeen;	// Address NACK this round
	logic								tick0;
	logic								tick2;
	logic								tick3;

	assign tick0 = tick && (phase == 2'd0);		// SCL just fell
	assign tick2 = tick && (phase == 2'd2);		// SCL just rose
	assign tick3 = tick && (phase == 2'd3);		// SCL high, mid

	assign keyPad = dataSh;

	//------------------------------------------------------------------
	// Transaction FSM
	//------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state		<= i2cPkg::IDLE;
			bitCnt		<= '0;
			sdaLow		<= 1'b0;
			run			<= 1'b0;
			nackSeen	<= 1'b0;
			seqComp		<= 1'b0;
			addrNack	<= 1'b0;
		end
		else
		begin
			seqComp		<= 1'b0;
			addrNack	<= 1'b0;
			case (state)
				i2cPkg::IDLE:
					if (en && tick2)	// Phase parked at 2
					begin
						run		<= 1'b1;
						state	<= i2cPkg::START;
					end
				i2cPkg::START:
					if (tick3)
						sdaLow <= 1'b1;	// START condition
					else if (tick0)
					begin
						nackSeen	<= 1'b0;
						bitCnt		<= 3'd7;
						sdaLow		<= ~lpAddrByte[7];
						state		<= i2cPkg::ADDR;
					end
				i2cPkg::ADDR:
					if (tick0)
					begin
						if (bitCnt == 3'd0)
						begin
							sdaLow	<= 1'b0;	// Release for slave ACK
							state	<= i2cPkg::ADDR_ACK;
						end
						else
						begin
							sdaLow	<= ~lpAddrByte[bitCnt - 3'd1];
							bitCnt	<= bitCnt - 3'd1;
						end
					end
				i2cPkg::ADDR_ACK:
					if (tick2 && sdaIn)
					begin
						nackSeen	<= 1'b1;
						addrNack	<= 1'b1;
					end
					else if (tick0)
					begin
						bitCnt	<= 3'd7;
						sdaLow	<= nackSeen;	// Low ahead of STOP on NACK
						state	<= nackSeen ? i2cPkg::STOP : i2cPkg::RDHI;
					end
				i2cPkg::RDHI, i2cPkg::RDLO:
					if (tick0)
					begin
						if (bitCnt != 3'd0)
							bitCnt <= bitCnt - 3'd1;
						else if (state == i2cPkg::RDHI)
						begin
							sdaLow	<= 1'b1;	// Master ACK
							state	<= i2cPkg::ACKHI;
						end
						else
						begin
							sdaLow	<= 1'b0;	// Master NACK, last byte
							state	<= i2cPkg::NACKLO;
						end
					end
				i2cPkg::ACKHI:
					if (tick0)
					begin
						sdaLow	<= 1'b0;
						bitCnt	<= 3'd7;
						state	<= i2cPkg::RDLO;
					end
				i2cPkg::NACKLO:
					if (tick0)
					begin
						sdaLow	<= 1'b1;	// Low under rising SCL
						state	<= i2cPkg::STOP;
					end
				i2cPkg::STOP:
					if (tick3)
					begin
						sdaLow	<= 1'b0;		// STOP condition
						seqComp	<= ~nackSeen;	// Keypad only on a good read
						state	<= i2cPkg::GAP;
					end
				i2cPkg::GAP:
					if (tick0)
					begin
						if (en)
							state <= i2cPkg::START;
						else
						begin
							run		<= 1'b0;	// Finished, park SCL high
							state	<= i2cPkg::IDLE;
						end
					end
				default:
					state <= i2cPkg::IDLE;
			endcase
		end
	end

	// Shift register holds payload only
	always_ff @(posedge sysClk)
	begin
		if (tick2 && ((state == i2cPkg::RDHI) || (state == i2cPkg::RDLO)))
			dataSh <= {dataSh[i2cPkg::KEYPAD_BITS-2:0], sdaIn};
	end

endmodule

`default_nettype wire

//--- hw/I2CUnit.sv
/* I2C engine: SCL is push-pull with no clock stretching, SDA is open drain and needs an
   external pull-up. SDA is sampled through a two-flop synchronizer. */
`timescale 1ns/1ps
`default_nettype none

module I2CUnit #(
	parameter	logic	[6:0]	pDevAdrs = 7'h20	// 7-bit slave address
)(
	input	wire		sysClk,
	input	wire		rstN,
	i2cCtrlIf.unit		ctrl,
	output	logic		i2cScl,
	inout	wire		i2cSda
);

	logic			tick;		// Quarter-bit strobe
	logic	[1:0]	phase;		// Quarter within the bit
	logic			sclGen;
	logic			run;		// Sequencer busy
	logic			sdaLow;		// Pull SDA down
	logic			sdaMeta;
	logic			sdaSync;

	//------------------------------------------------------------------
	// SDA pin
	//------------------------------------------------------------------
	assign i2cSda = sdaLow ? 1'b0 : 1'bz;	// Release means high via pull-up

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sdaMeta <= 1'b1;
			sdaSync <= 1'b1;
		end
		else
		begin
			sdaMeta <= i2cSda;
			sdaSync <= sdaMeta;
		end
	end

	assign i2cScl = sclGen | ~run;	// Held high while idle

	I2CSclGen sclGenInst (
		.sysClk	(sysClk),
		.rstN	(rstN),
		.div	(ctrl.div),
		.run	(run),
		.tick	(tick),
		.phase	(phase),
		.scl	(sclGen)
	);

	I2CKeyPadSeq #(
		.pDevAdrs	(pDevAdrs)
	) seqInst (
		.sysClk		(sysClk),
		.rstN		(rstN),
		.en			(ctrl.en),
		.tick		(tick),
		.phase		(phase),
		.sdaIn		(sdaSync),
		.sdaLow		(sdaLow),
		.run		(run),
		.keyPad		(ctrl.keyPad),
		.seqComp	(ctrl.seqComp),
		.addrNack	(ctrl.addrNack)
	);

endmodule

`default_nettype wire

//--- hw/I2CCsr.sv
/* Control and status registers. Unmapped offsets read zero; a status strobe and a
   write-1 clear in the same cycle leave the flag set. */
`timescale 1ns/1ps
`default_nettype none

module I2CCsr #(
	parameter							pBlockAdrsMap	= 8,
	parameter	[pBlockAdrsMap-1:0]		pAdrsMap		= 'h04,
	parameter							pBusAdrsBit		= 32
)(
	input	wire								sysClk,
	input	wire								rstN,
	input	wire	[i2cPkg::BUS_DATA_BITS-1:0]	usiWd,
	input	wire	[pBusAdrsBit-1:0]			usiAdrs,
	input	wire								usiWCke,
	output	logic	[i2cPkg::BUS_DATA_BITS-1:0]	usiRd,
	output	logic								usiVd,
	i2cCtrlIf.csr								ctrl
);

	localparam int lpPadDiv	= i2cPkg::BUS_DATA_BITS - i2cPkg::I2C_DIV_BITS;
	localparam int lpPadKey	= i2cPkg::BUS_DATA_BITS - i2cPkg::KEYPAD_BITS;

	//------------------------------------------------------------------
	// Address decode
	//------------------------------------------------------------------
	logic			blockHit;	// Upper field matches this block
	logic	[3:0]	regOfs;		// Byte offset inside the block
	logic			wrEn;

	assign blockHit	= (usiAdrs[pBusAdrsBit-1 -: pBlockAdrsMap] == pAdrsMap);
	assign regOfs	= usiAdrs[3:0];
	assign wrEn		= usiWCke & blockHit;

	//------------------------------------------------------------------
	// Registers
	//------------------------------------------------------------------
	logic								enReg;
	logic	[i2cPkg::I2C_DIV_BITS-1:0]	divReg;
	logic	[i2cPkg::KEYPAD_BITS-1:0]	keyPadReg;
	logic								seqCompFlag;	// Sticky
	logic								addrNackFlag;	// Sticky
	logic								clrComp;
	logic								clrNack;

	// Write 1 to clear
	assign clrComp = wrEn && (regOfs == i2cPkg::REG_STATUS) && usiWd[0];
	assign clrNack = wrEn && (regOfs == i2cPkg::REG_STATUS) && usiWd[1];

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enReg			<= 1'b0;
			divReg			<= '1;		// Slowest SCL out of reset
			keyPadReg		<= '0;
			seqCompFlag		<= 1'b0;
			addrNackFlag	<= 1'b0;
		end
		else
		begin
			if (wrEn && (regOfs == i2cPkg::REG_CTRL))
				enReg <= usiWd[0];
			if (wrEn && (regOfs == i2cPkg::REG_DIV))
				divReg <= usiWd[i2cPkg::I2C_DIV_BITS-1:0];
			if (ctrl.seqComp)
				keyPadReg <= ctrl.keyPad;	// Only good reads land here
			seqCompFlag		<= ctrl.seqComp | (seqCompFlag & ~clrComp);	// Set wins
			addrNackFlag	<= ctrl.addrNack | (addrNackFlag & ~clrNack);
		end
	end

	assign ctrl.en	= enReg;
	assign ctrl.div	= divReg;

	//------------------------------------------------------------------
	// Read mux, one cycle after the address
	//------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			usiRd <= '0;
			usiVd <= 1'b0;
		end
		else
		begin
			usiVd <= blockHit;
			if (!blockHit)
				usiRd <= '0;
			else
			begin
				case (regOfs)
					i2cPkg::REG_CTRL:	usiRd <= {{(i2cPkg::BUS_DATA_BITS-1){1'b0}}, enReg};
					i2cPkg::REG_DIV:	usiRd <= {{lpPadDiv{1'b0}}, divReg};
					i2cPkg::REG_KEYPAD:	usiRd <= {{lpPadKey{1'b0}}, keyPadReg};
					i2cPkg::REG_STATUS:
						usiRd <= {{(i2cPkg::BUS_DATA_BITS-2){1'b0}}, addrNackFlag, seqCompFlag};
					default:			usiRd <= '0;	// Unmapped
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/I2CBlock.sv
/* I2C keypad reader on the register bus. The block answers when the upper pBlockAdrsMap
   address bits equal pAdrsMap; reads are continuous with one cycle of latency. */
`timescale 1ns/1ps
`default_nettype none

module I2CBlock #(
	parameter							pBlockAdrsMap	= 8,		// Block field width
	parameter	[pBlockAdrsMap-1:0]		pAdrsMap		= 'h04,		// Block address
	parameter							pBusAdrsBit		= 32,		// Bus address width
	parameter	logic	[6:0]			pDevAdrs		= 7'h20		// Port expander address
)(
	// Bus slave write
	input	wire	[i2cPkg::BUS_DATA_BITS-1:0]	usiWd,
	input	wire	[pBusAdrsBit-1:0]			usiAdrs,
	input	wire								usiWCke,	// Single-cycle write strobe
	// Bus slave read
	output	logic	[i2cPkg::BUS_DATA_BITS-1:0]	usiRd,
	output	logic								usiVd,		// Previous address hit this block
	// I2C pins
	output	logic								i2cScl,		// Push-pull
	inout	wire								i2cSda,		// Open drain, needs pull-up
	// Clock and reset
	input	wire								sysClk,
	input	wire								rstN
);

	i2cCtrlIf ctrlIf ();

	//------------------------------------------------------------------
	// Register space
	//------------------------------------------------------------------
	I2CCsr #(
		.pBlockAdrsMap	(pBlockAdrsMap),
		.pAdrsMap		(pAdrsMap),
		.pBusAdrsBit	(pBusAdrsBit)
	) csr (
		.sysClk		(sysClk),
		.rstN		(rstN),
		.usiWd		(usiWd),
		.usiAdrs	(usiAdrs),
		.usiWCke	(usiWCke),
		.usiRd		(usiRd),
		.usiVd		(usiVd),
		.ctrl		(ctrlIf.csr)
	);

	//------------------------------------------------------------------
	// I2C engine
	//------------------------------------------------------------------
	I2CUnit #(
		.pDevAdrs	(pDevAdrs)
	) unit (
		.sysClk		(sysClk),
		.rstN		(rstN),
		.ctrl		(ctrlIf.unit),
		.i2cScl		(i2cScl),
		.i2cSda		(i2cSda)
	);

endmodule

`default_nettype wire

//--- tb/i2cKeyPadModel.sv
/* Behavioral 16-bit port expander slave: answers any address, no clock stretching.
   Random data and random address NACKs come from its own seeded generator. */
`timescale 1ns/1ps
`default_nettype none

module i2cKeyPadModel #(
	parameter int pSeed = 32'h60f2b128
)(
	input	wire	scl,
	inout	wire	sda		// Needs pull-up on the line
);

	logic				pullLow;		// Open-drain drive
	int					seed;
	int					startCount;		// STARTs seen
	int					stopCount;		// STOPs seen
	logic	[7:0]		addrSeen[$];	// Address byte per transaction
	logic	[15:0]		sentWords[$];	// Only for acknowledged reads
	bit					nackSent[$];	// One entry per transaction

	assign sda = pullLow ? 1'b0 : 1'bz;

	// STOP, SDA rises while SCL high, only once a START opened a transaction
	always @(posedge sda)
		if ((scl === 1'b1) && (stopCount < startCount))
			stopCount++;

	// Drives one byte MSB first, first bit at the current SCL low phase
	task automatic sendByte(input logic [7:0] b);
		int i;
		pullLow = ~b[7];
		for (i = 6; i >= 0; i--)
		begin
			@(negedge scl);
			pullLow = ~b[i];
		end
	endtask

	//------------------------------------------------------------------
	// Slave transaction loop
	//------------------------------------------------------------------
	initial
	begin : slaveLoop
		logic	[7:0]	adr;
		logic	[15:0]	word;
		bit				nack;
		int				i;
		pullLow		= 1'b0;
		seed		= pSeed;
		startCount	= 0;
		stopCount	= 0;
		adr			= '0;
		forever
		begin
			do
				@(negedge sda);
			while (scl !== 1'b1);	// START
			startCount++;
			for (i = 0; i < 8; i++)
			begin
				@(posedge scl);
				adr = {adr[6:0], sda};
			end
			addrSeen.push_back(adr);
			nack = (($random(seed) & 3) == 0);	// About one in four
			nackSent.push_back(nack);
			@(negedge scl);
			pullLow = ~nack;	// ACK slot
			@(negedge scl);
			if (nack)
				pullLow = 1'b0;
			else
			begin
				word = $random(seed);
				sentWords.push_back(word);
				sendByte(word[15:8]);	// High half first
				@(negedge scl);
				pullLow = 1'b0;		// Master ACK slot
				@(negedge scl);
				sendByte(word[7:0]);
				@(negedge scl);
				pullLow = 1'b0;		// Master NACK slot
			end
		end
	end

endmodule

`default_nettype wire

//--- tb/tbI2CBlock.sv
/* Testbench for the I2C keypad block with a behavioral slave on a pulled-up SDA line.
   The first divider change waits out the 0xFFFF reset reload, about 1.3 ms. */
`timescale 1ns/1ps
`default_nettype none

module tbI2CBlock;

	localparam int			BLK_BITS	= 8;
	localparam logic [7:0]	BLK_MAP		= 8'h04;
	localparam int			ADR_BITS	= 32;
	localparam logic [6:0]	DEV_ADRS	= 7'h20;
	localparam int			ROUNDS		= 4;
	localparam int			PER_ROUND	= 3;	// Transactions per divider
	localparam int			MAX_TRANS	= 20;
	localparam longint		WATCHDOG_NS	= MAX_TRANS * 30 * 4 * (7 + 1) * 20 + 2_000_000;

	logic								sysClk;
	logic								rstN;
	logic	[i2cPkg::BUS_DATA_BITS-1:0]	usiWd;
	logic	[ADR_BITS-1:0]				usiAdrs;
	logic								usiWCke;
	logic	[i2cPkg::BUS_DATA_BITS-1:0]	usiRd;
	logic								usiVd;
	logic								i2cScl;
	tri1								sdaLine;	// Pull-up
	int									seed;
	int									checkedCount;	// Transactions verified
	logic	[i2cPkg::KEYPAD_BITS-1:0]	expKey;			// Last good word

	I2CBlock #(
		.pBlockAdrsMap	(BLK_BITS),
		.pAdrsMap		(BLK_MAP),
		.pBusAdrsBit	(ADR_BITS),
		.pDevAdrs		(DEV_ADRS)
	) UUT (
		.usiWd		(usiWd),
		.usiAdrs	(usiAdrs),
		.usiWCke	(usiWCke),
		.usiRd		(usiRd),
		.usiVd		(usiVd),
		.i2cScl		(i2cScl),
		.i2cSda		(sdaLine),
		.sysClk		(sysClk),
		.rstN		(rstN)
	);

	i2cKeyPadModel #(.pSeed(32'h60f2b128)) keyPadModel (.scl(i2cScl), .sda(sdaLine));

	always #10 sysClk = ~sysClk;	// 20 ns

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the transactions did not finish in time");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	//------------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------------
	task automatic stopOnError();
		$display("TEST FAILED");
		$fatal(1, "mismatch");
	endtask

	task automatic checkBusWord(input string name, input logic [i2cPkg::BUS_DATA_BITS-1:0] exp,
			input logic [i2cPkg::BUS_DATA_BITS-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			stopOnError();
		end
	endtask

	task automatic checkKeyPad(input string name, input logic [i2cPkg::KEYPAD_BITS-1:0] exp,
			input logic [i2cPkg::KEYPAD_BITS-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			stopOnError();
		end
	endtask

	task automatic checkStatus(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
			stopOnError();
		end
	endtask

	task automatic checkAddrByte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
			stopOnError();
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
			stopOnError();
		end
	endtask

	task automatic checkPeriod(input string name, input longint exp, input longint act);
		if (act != exp)
		begin
			$display("[FAIL] %0t %s expected %0d ns got %0d ns", $time, name, exp, act);
			stopOnError();
		end
	endtask

	//------------------------------------------------------------------
	// Bus access
	//------------------------------------------------------------------
	function automatic logic [ADR_BITS-1:0] regAdrs(input logic [3:0] ofs);
		return {BLK_MAP, 20'h0, ofs};
	endfunction

	task automatic busWrite(input logic [3:0] ofs, input logic [31:0] data);
		@(posedge sysClk);
		usiAdrs	<= regAdrs(ofs);
		usiWd	<= data;
		usiWCke	<= 1'b1;
		@(posedge sysClk);
		usiWCke	<= 1'b0;
	endtask

	// Data is registered one cycle after the address
	task automatic busRead(input logic [ADR_BITS-1:0] adr, output logic [31:0] data,
			output logic vd);
		@(posedge sysClk);
		usiAdrs	<= adr;
		usiWCke	<= 1'b0;
		@(posedge sysClk);
		@(negedge sysClk);
		data	= usiRd;
		vd		= usiVd;
	endtask

	// Waits for the next STOP and checks status, keypad and address byte
	task automatic checkTransaction();
		logic	[31:0]	rd;
		logic			vd;
		bit				nack;
		wait (keyPadModel.stopCount > checkedCount);
		checkedCount++;
		repeat (3) @(posedge sysClk);	// Flag settles after the strobe
		if (keyPadModel.addrSeen.size() == 0 || keyPadModel.nackSent.size() == 0)
		begin
			$display("The slave saw a STOP without a complete address byte");
			stopOnError();
		end
		checkAddrByte("addrByte", {DEV_ADRS, 1'b1}, keyPadModel.addrSeen.pop_front());
		nack = keyPadModel.nackSent.pop_front();
		if (!nack)
			expKey = keyPadModel.sentWords.pop_front();	// NACK keeps the old word
		busRead(regAdrs(i2cPkg::REG_STATUS), rd, vd);
		checkStatus("status", nack ? 2'b10 : 2'b01, rd[1:0]);
		busRead(regAdrs(i2cPkg::REG_KEYPAD), rd, vd);
		checkFlag("usiVd", 1'b1, vd);
		checkKeyPad("keyPad", expKey, rd[i2cPkg::KEYPAD_BITS-1:0]);
		busWrite(i2cPkg::REG_STATUS, 32'h3);	// Clear both
		busRead(regAdrs(i2cPkg::REG_STATUS), rd, vd);
		checkStatus("status", 2'b00, rd[1:0]);
	endtask

	//------------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------------
	initial
	begin : mainFlow
		logic	[31:0]	rd;
		logic	[31:0]	wd;
		logic			vd;
		int				div;
		int				r;
		int				startsBefore;
		longint			t1;
		longint			t2;
		sysClk = 1'b0;
		rstN = 1'b0;
		usiWd = '0;
		usiAdrs = '0;
		usiWCke = 1'b0;
		seed = 32'h60f2b128;
		checkedCount = 0;
		expKey = '0;
		repeat (3) @(posedge sysClk);
		rstN <= 1'b1;

		// Register access, engine kept disabled
		for (r = 0; r < 6; r++)
		begin
			wd = $random(seed);
			busWrite(i2cPkg::REG_DIV, wd);
			busRead(regAdrs(i2cPkg::REG_DIV), rd, vd);
			checkFlag("usiVd", 1'b1, vd);
			checkBusWord("DIV", {16'h0, wd[15:0]}, rd);
			wd = $random(seed) & 32'hFFFF_FFFE;
			busWrite(i2cPkg::REG_CTRL, wd);
			busRead(regAdrs(i2cPkg::REG_CTRL), rd, vd);
			checkBusWord("CTRL", 32'h0, rd);
			busWrite(i2cPkg::REG_KEYPAD, $random(seed));	// Read only
			busRead(regAdrs(i2cPkg::REG_KEYPAD), rd, vd);
			checkBusWord("KEYPAD", 32'h0, rd);
		end
		busRead({8'h05, 20'h0, i2cPkg::REG_KEYPAD}, rd, vd);	// Other block
		checkFlag("usiVd", 1'b0, vd);
		busRead(regAdrs(4'h2), rd, vd);		// Unmapped offset
		checkBusWord("unmapped", 32'h0, rd);

		// Random dividers, keypad reads, flags and disable
		for (r = 0; r < ROUNDS; r++)
		begin
			div = ($unsigned($random(seed)) % 7) + 1;
			busWrite(i2cPkg::REG_DIV, div);
			busRead(regAdrs(i2cPkg::REG_DIV), rd, vd);
			checkBusWord("DIV", div, rd);
			startsBefore = keyPadModel.startCount;
			busWrite(i2cPkg::REG_CTRL, 32'h1);
			busRead(regAdrs(i2cPkg::REG_CTRL), rd, vd);
			checkBusWord("CTRL", 32'h1, rd);
			wait (keyPadModel.startCount > startsBefore);
			@(posedge i2cScl);
			t1 = $time;
			@(posedge i2cScl);
			t2 = $time;
			checkPeriod("sclPeriod", 4 * (div + 1) * 20, t2 - t1);
			repeat (PER_ROUND) checkTransaction();
			busWrite(i2cPkg::REG_CTRL, 32'h0);
			repeat (8 * (div + 1)) @(posedge sysClk);	// Let a pending START show
			while (keyPadModel.startCount > checkedCount)
				checkTransaction();		// Running one finishes
			repeat (12 * (div + 1)) @(posedge sysClk);
			checkFlag("i2cScl", 1'b1, i2cScl);
			checkFlag("i2cSda", 1'b1, sdaLine);
			checkBusWord("startCount", checkedCount, keyPadModel.startCount);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hw/i2cPkg.sv
hw/i2cCtrlIf.sv
hw/I2CSclGen.sv
hw/I2CKeyPadSeq.sv
hw/I2CUnit.sv
hw/I2CCsr.sv
hw/I2CBlock.sv
tb/i2cKeyPadModel.sv
tb/tbI2CBlock.sv

//--- Bender.yml
package:
  name: i2c_keypad

sources:
  - hw/i2cPkg.sv
  - hw/i2cCtrlIf.sv
  - hw/I2CSclGen.sv
  - hw/I2CKeyPadSeq.sv
  - hw/I2CUnit.sv
  - hw/I2CCsr.sv
  - hw/I2CBlock.sv
  - target: test
    files:
      - tb/i2cKeyPadModel.sv
      - tb/tbI2CBlock.sv
